/* hdl/flit_pkg.sv */
package flit_pkg;

    localparam int FLIT_W    = 32;
    localparam int KIND_W    = 2;
    localparam int COORD_W   = 3;
    localparam int PAYLOAD_W = 21;

    // credit flits carry the count below the kind field
    localparam int CREDIT_W  = 30;

    // data flit: kind | dst x | dst y | dst z | payload
    localparam int DST_Z_LSB = PAYLOAD_W;
    localparam int DST_Y_LSB = DST_Z_LSB + COORD_W;
    localparam int DST_X_LSB = DST_Y_LSB + COORD_W;
    localparam int KIND_LSB  = DST_X_LSB + COORD_W;

    // top bits of every flit
    typedef enum logic [KIND_W-1:0] {
        FLIT_DATA   = 2'b00,
        FLIT_CREDIT = 2'b01
    } flit_kind_e;

    typedef logic [FLIT_W-1:0] flit_t;

endpackage

/* hdl/router_pkg.sv */
package router_pkg;

    // link ports, also the array index everywhere
    typedef enum logic [2:0] {
        PORT_XPOS = 3'd0,
        PORT_YPOS = 3'd1,
        PORT_ZPOS = 3'd2,
        PORT_XNEG = 3'd3,
        PORT_YNEG = 3'd4,
        PORT_ZNEG = 3'd5
    } port_e;

    localparam int PORT_NUM = 6;

    // position of this node
    localparam int CUR_X = 3;
    localparam int CUR_Y = 4;
    localparam int CUR_Z = 5;

    localparam int QUEUE_DEPTH = 16;

    // holds 0 .. QUEUE_DEPTH
    localparam int USED_W = 5;

    // one credit slot every CREDIT_PERIOD cycles
    localparam int CREDIT_PERIOD    = 32;
    localparam int CREDIT_THRESHOLD = 8;

endpackage

/* hdl/credit_intake.sv */
`timescale 1ns/1ns

module credit_intake
    import flit_pkg::*;
    import router_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  flit_t in_flit          [PORT_NUM],
    input  logic  in_valid         [PORT_NUM],
    output logic  push             [PORT_NUM],
    output flit_t push_flit        [PORT_NUM],
    output logic  downstream_avail [PORT_NUM]
);

    flit_kind_e          in_kind  [PORT_NUM];
    logic                is_credit [PORT_NUM];
    logic [CREDIT_W-1:0] credits  [PORT_NUM];

    always_comb begin
        for (int p = 0; p < PORT_NUM; p++) begin
            in_kind[p]   = flit_kind_e'(in_flit[p][KIND_LSB +: KIND_W]);
            is_credit[p] = in_valid[p] && (in_kind[p] == FLIT_CREDIT);

            // only data goes into the queue
            push[p]      = in_valid[p] && (in_kind[p] == FLIT_DATA);
            push_flit[p] = in_flit[p];

            downstream_avail[p] = (credits[p] >= CREDIT_THRESHOLD);
        end
    end

    // free space reported by the neighbour on each link
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int p = 0; p < PORT_NUM; p++) begin
                credits[p] <= CREDIT_W'(QUEUE_DEPTH - 1);
            end
        end else begin
            for (int p = 0; p < PORT_NUM; p++) begin
                if (is_credit[p]) begin
                    credits[p] <= in_flit[p][CREDIT_W-1:0];
                end
            end
        end
    end

endmodule

/* hdl/flit_queue.sv */
`timescale 1ns/1ns

module flit_queue
    import flit_pkg::*;
    import router_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              push,
    input  flit_t             push_flit,
    input  logic              pop,
    output flit_t             head_flit,
    output logic              head_valid,
    output logic [USED_W-1:0] used
);

    flit_t mem [QUEUE_DEPTH];

    logic [$clog2(QUEUE_DEPTH)-1:0] wr_ptr;
    logic [$clog2(QUEUE_DEPTH)-1:0] rd_ptr;
    logic [USED_W-1:0]              count;
    logic                           do_push;
    logic                           do_pop;

    // full queue drops the push
    assign do_push = push && (count != USED_W'(QUEUE_DEPTH));
    assign do_pop  = pop && (count != '0);

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_flit;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // fall-through head
    assign head_flit  = mem[rd_ptr];
    assign head_valid = (count != '0);
    assign used       = count;

endmodule

/* hdl/route_switch.sv */
`timescale 1ns/1ns

module route_switch
    import flit_pkg::*;
    import router_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  flit_t head_flit   [PORT_NUM],
    input  logic  head_valid  [PORT_NUM],
    input  logic  out_ready   [PORT_NUM],
    output logic  pop         [PORT_NUM],
    output flit_t sw_flit     [PORT_NUM],
    output logic  sw_valid    [PORT_NUM],
    output flit_t eject_flit  [PORT_NUM],
    output logic  eject_valid [PORT_NUM]
);

    port_e req_port  [PORT_NUM];
    logic  req_eject [PORT_NUM];
    logic  req_link  [PORT_NUM];

    function automatic logic at_node(input flit_t f);
        return (f[DST_X_LSB +: COORD_W] == CUR_X) &&
               (f[DST_Y_LSB +: COORD_W] == CUR_Y) &&
               (f[DST_Z_LSB +: COORD_W] == CUR_Z);
    endfunction

    // x first, then y, then z; no wraparound
    function automatic port_e route_port(input flit_t f);
        logic [COORD_W-1:0] dx;
        logic [COORD_W-1:0] dy;
        logic [COORD_W-1:0] dz;
        dx = f[DST_X_LSB +: COORD_W];
        dy = f[DST_Y_LSB +: COORD_W];
        dz = f[DST_Z_LSB +: COORD_W];
        if (dx != CUR_X) begin
            return (dx > CUR_X) ? PORT_XPOS : PORT_XNEG;
        end else if (dy != CUR_Y) begin
            return (dy > CUR_Y) ? PORT_YPOS : PORT_YNEG;
        end else if (dz > CUR_Z) begin
            return PORT_ZPOS;
        end else begin
            return PORT_ZNEG;
        end
    endfunction

    always_comb begin
        for (int p = 0; p < PORT_NUM; p++) begin
            req_port[p]  = route_port(head_flit[p]);
            req_eject[p] = head_valid[p] && at_node(head_flit[p]);
            req_link[p]  = head_valid[p] && !at_node(head_flit[p]);
        end
    end

    // one fixed-priority arbiter per output, port 0 wins
    always_comb begin
        for (int p = 0; p < PORT_NUM; p++) begin
            pop[p] = req_eject[p];
        end
        for (int o = 0; o < PORT_NUM; o++) begin
            sw_valid[o] = 1'b0;
            sw_flit[o]  = '0;
            for (int p = 0; p < PORT_NUM; p++) begin
                if (!sw_valid[o] && out_ready[o] && req_link[p] &&
                    (req_port[p] == port_e'(o))) begin
                    sw_valid[o] = 1'b1;
                    sw_flit[o]  = head_flit[p];
                    pop[p]      = 1'b1;
                end
            end
        end
    end

    // eject never stalls
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int p = 0; p < PORT_NUM; p++) begin
                eject_valid[p] <= 1'b0;
            end
        end else begin
            for (int p = 0; p < PORT_NUM; p++) begin
                eject_valid[p] <= req_eject[p];
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int p = 0; p < PORT_NUM; p++) begin
            eject_flit[p] <= head_flit[p];
        end
    end

endmodule

/* hdl/credit_return.sv */
`timescale 1ns/1ns

module credit_return
    import flit_pkg::*;
    import router_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic [USED_W-1:0] used             [PORT_NUM],
    input  logic              downstream_avail [PORT_NUM],
    input  flit_t             sw_flit          [PORT_NUM],
    input  logic              sw_valid         [PORT_NUM],
    output logic              out_ready        [PORT_NUM],
    output flit_t             out_flit         [PORT_NUM],
    output logic              out_valid        [PORT_NUM]
);

    logic [$clog2(CREDIT_PERIOD)-1:0] period_cnt;
    logic                             slot;
    logic [USED_W-1:0]                free_cnt    [PORT_NUM];
    flit_t                            credit_flit [PORT_NUM];

    always_ff @(posedge clk) begin
        if (rst || slot) begin
            period_cnt <= '0;
        end else begin
            period_cnt <= period_cnt + 1'b1;
        end
    end

    // last count of the period is the credit slot
    assign slot = (period_cnt == CREDIT_PERIOD - 1);

    always_comb begin
        for (int p = 0; p < PORT_NUM; p++) begin
            out_ready[p] = downstream_avail[p] && !slot;
            // saturate at zero when the queue is completely full
            if (used[p] >= USED_W'(QUEUE_DEPTH - 1)) begin
                free_cnt[p] = '0;
            end else begin
                free_cnt[p] = USED_W'(QUEUE_DEPTH - 1) - used[p];
            end
            credit_flit[p] = {FLIT_CREDIT, CREDIT_W'(free_cnt[p])};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int p = 0; p < PORT_NUM; p++) begin
                out_valid[p] <= 1'b0;
            end
        end else begin
            for (int p = 0; p < PORT_NUM; p++) begin
                out_valid[p] <= slot || sw_valid[p];
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int p = 0; p < PORT_NUM; p++) begin
            out_flit[p] <= slot ? credit_flit[p] : sw_flit[p];
        end
    end

endmodule

/* hdl/router_top.sv */
`timescale 1ns/1ns

module router_top
    import flit_pkg::*;
    import router_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  flit_t in_flit     [PORT_NUM],
    input  logic  in_valid    [PORT_NUM],
    output flit_t out_flit    [PORT_NUM],
    output logic  out_valid   [PORT_NUM],
    output flit_t eject_flit  [PORT_NUM],
    output logic  eject_valid [PORT_NUM]
);

    logic              push             [PORT_NUM];
    flit_t             push_flit        [PORT_NUM];
    logic              downstream_avail [PORT_NUM];
    flit_t             head_flit        [PORT_NUM];
    logic              head_valid       [PORT_NUM];
    logic [USED_W-1:0] used             [PORT_NUM];
    logic              pop              [PORT_NUM];
    logic              out_ready        [PORT_NUM];
    flit_t             sw_flit          [PORT_NUM];
    logic              sw_valid         [PORT_NUM];

    credit_intake i_credit_intake (
        .clk              (clk),
        .rst              (rst),
        .in_flit          (in_flit),
        .in_valid         (in_valid),
        .push             (push),
        .push_flit        (push_flit),
        .downstream_avail (downstream_avail)
    );

    // one input queue per link
    generate
        for (genvar p = 0; p < PORT_NUM; p++) begin : g_queue
            flit_queue i_flit_queue (
                .clk        (clk),
                .rst        (rst),
                .push       (push[p]),
                .push_flit  (push_flit[p]),
                .pop        (pop[p]),
                .head_flit  (head_flit[p]),
                .head_valid (head_valid[p]),
                .used       (used[p])
            );
        end
    endgenerate

    route_switch i_route_switch (
        .clk         (clk),
        .rst         (rst),
        .head_flit   (head_flit),
        .head_valid  (head_valid),
        .out_ready   (out_ready),
        .pop         (pop),
        .sw_flit     (sw_flit),
        .sw_valid    (sw_valid),
        .eject_flit  (eject_flit),
        .eject_valid (eject_valid)
    );

    credit_return i_credit_return (
        .clk              (clk),
        .rst              (rst),
        .used             (used),
        .downstream_avail (downstream_avail),
        .sw_flit          (sw_flit),
        .sw_valid         (sw_valid),
        .out_ready        (out_ready),
        .out_flit         (out_flit),
        .out_valid        (out_valid)
    );

endmodule

/* verification/router_checker.sv */
`timescale 1ns/1ns

module router_checker
    import flit_pkg::*;
    import router_pkg::*;
(
    input logic  clk,
    input logic  rst,
    input flit_t in_flit      [PORT_NUM],
    input logic  in_valid     [PORT_NUM],
    input flit_t out_flit     [PORT_NUM],
    input logic  out_valid    [PORT_NUM],
    input flit_t eject_flit   [PORT_NUM],
    input logic  eject_valid  [PORT_NUM],
    input logic  credit_check
);

    // source port sits in the top payload bits
    localparam int SRC_LSB = PAYLOAD_W - 3;

    // link queues indexed by output * PORT_NUM + source
    flit_t exp_link  [PORT_NUM*PORT_NUM][$];
    flit_t exp_eject [PORT_NUM][$];

    int   errors      = 0;
    int   test_errors = 0;
    int   tests       = 0;
    int   checks      = 0;
    int   sent        = 0;
    int   delivered   = 0;
    int   slots       = 0;
    int   cyc         = 0;
    int   last_slot   = 0;
    logic check_en    = 1'b0;

    task automatic report_error(input string msg);
        $display("%s", msg);
        errors++;
        test_errors++;
    endtask

    task automatic expect_flit(input int dst, input int src, input flit_t f);
        if (dst == PORT_NUM) begin
            exp_eject[src].push_back(f);
        end else begin
            exp_link[dst*PORT_NUM + src].push_back(f);
        end
    endtask

    function automatic int pending_link(input int dst);
        int n;
        n = 0;
        for (int s = 0; s < PORT_NUM; s++) begin
            n += exp_link[dst*PORT_NUM + s].size();
        end
        return n;
    endfunction

    function automatic int pending_all();
        int n;
        n = 0;
        for (int p = 0; p < PORT_NUM; p++) begin
            n += pending_link(p) + exp_eject[p].size();
        end
        return n;
    endfunction

    task automatic check_link(input int p);
        flit_t f;
        int    idx;
        f   = out_flit[p];
        idx = p*PORT_NUM + int'(f[SRC_LSB +: 3]);
        if (f[SRC_LSB +: 3] >= PORT_NUM || exp_link[idx].size() == 0) begin
            report_error($sformatf("unexpected data flit %h on output %0d", f, p));
        end else begin
            checks++;
            delivered++;
            if (f !== exp_link[idx][0]) begin
                report_error($sformatf("ERR out_flit[%0d]: expected %h, got %h",
                                       p, exp_link[idx][0], f));
            end
            void'(exp_link[idx].pop_front());
        end
    endtask

    task automatic check_eject(input int p);
        flit_t f;
        f = eject_flit[p];
        if (f[KIND_LSB +: KIND_W] == FLIT_CREDIT) begin
            report_error($sformatf("credit flit showed up on eject port %0d", p));
        end else if (exp_eject[p].size() == 0) begin
            report_error($sformatf("unexpected flit %h on eject port %0d", f, p));
        end else begin
            checks++;
            delivered++;
            if (f !== exp_eject[p][0]) begin
                report_error($sformatf("ERR eject_flit[%0d]: expected %h, got %h",
                                       p, exp_eject[p][0], f));
            end
            void'(exp_eject[p].pop_front());
        end
    endtask

    // all six outputs together, one period after the last slot
    task automatic check_slot();
        int    n_credit;
        flit_t exp_credit;
        n_credit   = 0;
        exp_credit = {FLIT_CREDIT, CREDIT_W'(QUEUE_DEPTH - 1)};
        for (int p = 0; p < PORT_NUM; p++) begin
            if (out_valid[p] && out_flit[p][KIND_LSB +: KIND_W] == FLIT_CREDIT) begin
                n_credit++;
            end
        end
        if (n_credit == 0) begin
            return;
        end
        slots++;
        if (n_credit != PORT_NUM) begin
            report_error($sformatf("credit slot reached only %0d outputs", n_credit));
        end
        if (cyc - last_slot != CREDIT_PERIOD) begin
            report_error($sformatf("credit slot at cycle %0d came %0d cycles after the last one",
                                   cyc, cyc - last_slot));
        end
        last_slot = cyc;
        if (check_en) begin
            for (int p = 0; p < PORT_NUM; p++) begin
                checks++;
                if (out_flit[p] !== exp_credit) begin
                    report_error($sformatf("ERR out_flit[%0d]: expected %h, got %h",
                                           p, exp_credit, out_flit[p]));
                end
            end
        end
    endtask

    task automatic end_test(input string name);
        for (int i = 0; i < PORT_NUM*PORT_NUM; i++) begin
            if (exp_link[i].size() != 0) begin
                report_error($sformatf("%0d flits from input %0d never left output %0d",
                                       exp_link[i].size(), i % PORT_NUM, i / PORT_NUM));
                exp_link[i].delete();
            end
        end
        for (int p = 0; p < PORT_NUM; p++) begin
            if (exp_eject[p].size() != 0) begin
                report_error($sformatf("%0d flits never ejected on port %0d",
                                       exp_eject[p].size(), p));
                exp_eject[p].delete();
            end
        end
        tests++;
        $display("test %s: %s, %0d errors", name, (test_errors == 0) ? "ok" : "failed",
                 test_errors);
        test_errors = 0;
    endtask

    always @(posedge clk) begin
        check_en <= credit_check;
        if (rst) begin
            cyc <= 0;
        end else begin
            cyc <= cyc + 1;
            for (int p = 0; p < PORT_NUM; p++) begin
                if (in_valid[p] && in_flit[p][KIND_LSB +: KIND_W] == FLIT_DATA) begin
                    sent++;
                end
            end
        end
    end

    // outputs are registered, settled by the falling edge
    always @(negedge clk) begin
        if (!rst) begin
            for (int p = 0; p < PORT_NUM; p++) begin
                if (out_valid[p] && out_flit[p][KIND_LSB +: KIND_W] == FLIT_DATA) begin
                    check_link(p);
                end
                if (eject_valid[p]) begin
                    check_eject(p);
                end
            end
            check_slot();
        end
    end

endmodule

/* verification/router_tb.sv */
`timescale 1ns/1ns

module router_tb
    import flit_pkg::*;
    import router_pkg::*;
();

    localparam int EJECT  = PORT_NUM;
    localparam int RAND_W = PAYLOAD_W - 3;

    // ejection 24, random 48, contention 24, back-pressure 12 data and 2 credit
    localparam int TOTAL_FLITS    = 24 + 48 + 24 + 14;
    localparam int TIMEOUT_CYCLES = 4 * TOTAL_FLITS + 10 * CREDIT_PERIOD;

    logic        clk;
    logic        rst;
    flit_t       in_flit     [PORT_NUM];
    logic        in_valid    [PORT_NUM];
    flit_t       out_flit    [PORT_NUM];
    logic        out_valid   [PORT_NUM];
    flit_t       eject_flit  [PORT_NUM];
    logic        eject_valid [PORT_NUM];
    logic        credit_check;
    logic [31:0] lfsr_state;
    int          cycles = 0;

    router_top i_dut (
        .clk         (clk),
        .rst         (rst),
        .in_flit     (in_flit),
        .in_valid    (in_valid),
        .out_flit    (out_flit),
        .out_valid   (out_valid),
        .eject_flit  (eject_flit),
        .eject_valid (eject_valid)
    );

    router_checker i_checker (
        .clk          (clk),
        .rst          (rst),
        .in_flit      (in_flit),
        .in_valid     (in_valid),
        .out_flit     (out_flit),
        .out_valid    (out_valid),
        .eject_flit   (eject_flit),
        .eject_valid  (eject_valid),
        .credit_check (credit_check)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: run stopped after %0d cycles", cycles);
            $display("TB FAILED");
            $finish;
        end
    end

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output int v);
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = (v << 1) | int'(lfsr_state[0]);
        end
    endtask

    // x first, then y, then z, straight toward the destination
    function automatic int expected_port(input int x, input int y, input int z);
        if (x > CUR_X) return PORT_XPOS;
        if (x < CUR_X) return PORT_XNEG;
        if (y > CUR_Y) return PORT_YPOS;
        if (y < CUR_Y) return PORT_YNEG;
        if (z > CUR_Z) return PORT_ZPOS;
        if (z < CUR_Z) return PORT_ZNEG;
        return EJECT;
    endfunction

    task automatic idle_inputs();
        for (int p = 0; p < PORT_NUM; p++) begin
            in_valid[p] = 1'b0;
            in_flit[p]  = '0;
        end
    endtask

    task automatic step();
        @(negedge clk);
        idle_inputs();
    endtask

    // source port goes above the random payload bits
    task automatic send_data(input int src, input int x, input int y, input int z);
        int    r;
        flit_t f;
        take_bits(RAND_W, r);
        f = {FLIT_DATA, COORD_W'(x), COORD_W'(y), COORD_W'(z), 3'(src), RAND_W'(r)};
        in_flit[src]  = f;
        in_valid[src] = 1'b1;
        i_checker.expect_flit(expected_port(x, y, z), src, f);
    endtask

    task automatic send_credit(input int p, input int value);
        in_flit[p]  = {FLIT_CREDIT, CREDIT_W'(value)};
        in_valid[p] = 1'b1;
    endtask

    task automatic wait_drain(input int limit);
        int n;
        n = 0;
        while (i_checker.pending_all() != 0 && n < limit) begin
            @(negedge clk);
            n++;
        end
        repeat (4) @(negedge clk);
    endtask

    initial begin
        int x;
        int y;
        int z;
        int base;
        lfsr_state   = 32'h8094_85be;
        rst          = 1'b1;
        credit_check = 1'b0;
        idle_inputs();
        repeat (3) @(negedge clk);
        rst = 1'b0;

        for (int k = 0; k < 4; k++) begin
            step();
            for (int p = 0; p < PORT_NUM; p++) begin
                send_data(p, CUR_X, CUR_Y, CUR_Z);
            end
        end
        step();
        wait_drain(4 * 24 + 2 * CREDIT_PERIOD);
        i_checker.end_test("ejection");

        for (int k = 0; k < 8; k++) begin
            step();
            for (int p = 0; p < PORT_NUM; p++) begin
                take_bits(COORD_W, x);
                take_bits(COORD_W, y);
                take_bits(COORD_W, z);
                send_data(p, x, y, z);
            end
        end
        step();
        wait_drain(4 * 48 + 2 * CREDIT_PERIOD);
        i_checker.end_test("dimension order routing");

        // every input aims at xpos
        for (int k = 0; k < 4; k++) begin
            step();
            for (int p = 0; p < PORT_NUM; p++) begin
                take_bits(COORD_W, y);
                take_bits(COORD_W, z);
                send_data(p, 7, y, z);
            end
        end
        step();
        wait_drain(4 * 24 + 2 * CREDIT_PERIOD);
        i_checker.end_test("contention");

        step();
        credit_check = 1'b1;
        base = i_checker.slots;
        while (i_checker.slots < base + 3) @(negedge clk);
        credit_check = 1'b0;
        i_checker.end_test("credit return");

        // starve xpos, keep ypos traffic running beside it
        step();
        send_credit(PORT_XPOS, CREDIT_THRESHOLD - 6);
        step();
        for (int k = 0; k < 4; k++) begin
            step();
            take_bits(COORD_W, y);
            take_bits(COORD_W, z);
            send_data(PORT_YPOS, 7, y, z);
            send_data(PORT_ZNEG, 7, z, y);
            send_data(PORT_XNEG, CUR_X, 6, z);
        end
        step();
        base = 0;
        while (i_checker.pending_link(PORT_YPOS) != 0 && base < 4 * 12) begin
            @(negedge clk);
            base++;
        end
        repeat (8) @(negedge clk);
        if (i_checker.pending_link(PORT_YPOS) != 0) begin
            i_checker.report_error("output ypos stalled while xpos was held");
        end
        if (i_checker.pending_link(PORT_XPOS) != 8) begin
            i_checker.report_error($sformatf("output xpos sent %0d flits below the threshold",
                                             8 - i_checker.pending_link(PORT_XPOS)));
        end
        step();
        // release value also carries this node's address in the destination bits
        send_credit(PORT_XPOS, (CUR_X << DST_X_LSB) | (CUR_Y << DST_Y_LSB) |
                               (CUR_Z << DST_Z_LSB) | (CREDIT_THRESHOLD + 4));
        step();
        wait_drain(4 * 12 + 2 * CREDIT_PERIOD);
        i_checker.end_test("downstream back-pressure");

        $display("done: %0d tests, %0d checks, %0d data flits sent, %0d delivered, %0d errors",
                 i_checker.tests, i_checker.checks, i_checker.sent, i_checker.delivered,
                 i_checker.errors);
        if (i_checker.errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* filelist.f */
hdl/flit_pkg.sv
hdl/router_pkg.sv
hdl/credit_intake.sv
hdl/flit_queue.sv
hdl/route_switch.sv
hdl/credit_return.sv
hdl/router_top.sv
verification/router_checker.sv
verification/router_tb.sv
